// ==== src/core_cfg.svh ====
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// data path and address width.
`define XLEN 32

// first fetch address after reset.
`define RESET_PC 32'h0000_0000

// instruction memory depth, in 32-bit words.
`define IMEM_WORDS 256

// data memory size, in bytes.
`define DMEM_BYTES 1024

`endif

// ==== src/isa_pkg.sv ====
package isa_pkg;

  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  // compare ops return 0 or 1 in bit 0; slt and sltu also serve blt and bltu.
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
    ALU_OR, ALU_AND, ALU_PASS_B, ALU_EQ, ALU_NE, ALU_GE, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {NPC_SEQ, NPC_PCREL, NPC_REG, NPC_BRANCH} npc_sel_e;

  typedef enum logic [1:0] {WB_ALU, WB_PC4, WB_PCIMM, WB_MEM} wb_sel_e;

  typedef enum logic [1:0] {MEM_B = 2'd0, MEM_H = 2'd1, MEM_W = 2'd2} mem_size_e;

  // alu funct3.
  localparam logic [2:0] F3_ADD_SUB = 3'd0;
  localparam logic [2:0] F3_SLL     = 3'd1;
  localparam logic [2:0] F3_SLT     = 3'd2;
  localparam logic [2:0] F3_SLTU    = 3'd3;
  localparam logic [2:0] F3_XOR     = 3'd4;
  localparam logic [2:0] F3_SR      = 3'd5;
  localparam logic [2:0] F3_OR      = 3'd6;
  localparam logic [2:0] F3_AND     = 3'd7;

  // branch funct3.
  localparam logic [2:0] F3_BEQ  = 3'd0;
  localparam logic [2:0] F3_BNE  = 3'd1;
  localparam logic [2:0] F3_BLT  = 3'd4;
  localparam logic [2:0] F3_BGE  = 3'd5;
  localparam logic [2:0] F3_BLTU = 3'd6;
  localparam logic [2:0] F3_BGEU = 3'd7;

  localparam logic [31:0] ENC_EBREAK = 32'h0010_0073;

endpackage

// ==== src/core_pkg.sv ====
`include "core_cfg.svh"

package core_pkg;
  import isa_pkg::*;

  typedef struct packed {
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [4:0]       rd;
    logic [`XLEN-1:0] imm;
    logic             b_is_imm;
    logic             a_is_pc;
    alu_op_e          alu_op;
    npc_sel_e         npc_sel;
    wb_sel_e          wb_sel;
    logic             reg_wen;
    logic             mem_ren;
    logic             mem_wen;
    mem_size_e        mem_size;
    logic             mem_sext;
    logic             halt;
  } ctrl_t;

  typedef struct packed {
    logic                           en;
    logic [$clog2(`IMEM_WORDS)-1:0] addr; // word address.
    logic [31:0]                    data;
  } imem_load_t;

  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] pc;
    logic [31:0]      inst;
    logic [4:0]       rd;
    logic             reg_wen;
    logic [`XLEN-1:0] wdata;
  } retire_t;

endpackage

// ==== src/fetch_unit.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module fetch_unit import isa_pkg::*, core_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  imem_load_t       imem_load,
  input  logic             stall,
  input  npc_sel_e         npc_sel,
  input  logic [`XLEN-1:0] imm,
  input  logic [`XLEN-1:0] alu_result,
  output logic [`XLEN-1:0] pc,
  output logic [31:0]      inst
);

  localparam int AW = $clog2(`IMEM_WORDS);

  logic [31:0]      imem [`IMEM_WORDS];
  logic [`XLEN-1:0] snpc;
  logic [`XLEN-1:0] dnpc;
  logic [`XLEN-1:0] npc;

  always_ff @(posedge clk) begin
    if (imem_load.en) imem[imem_load.addr] <= imem_load.data;
  end

  assign inst = imem[pc[AW+1:2]];
  assign snpc = pc + `XLEN'd4;
  assign dnpc = pc + imm;

  always_comb begin
    case (npc_sel)
      NPC_SEQ:    npc = snpc;
      NPC_PCREL:  npc = dnpc;
      NPC_REG:    npc = {alu_result[`XLEN-1:1], 1'b0}; // jalr clears bit 0.
      NPC_BRANCH: npc = alu_result[0] ? dnpc : snpc;
      default:    npc = snpc;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RESET_PC;
    end else if (!stall) begin
      pc <= npc;
    end
  end

  a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("pc not word aligned: %h", pc);

endmodule

// ==== src/decode_unit.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module decode_unit import isa_pkg::*, core_pkg::*; (
  input  logic [31:0] inst,
  output ctrl_t       ctrl
);

  opcode_e          opcode;
  logic [2:0]       funct3;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] imm_j;

  assign opcode = opcode_e'(inst[6:0]);
  assign funct3 = inst[14:12];

  assign imm_i = {{(`XLEN-12){inst[31]}}, inst[31:20]};
  assign imm_s = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{(`XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
    case (f3)
      F3_ADD_SUB: return alt ? ALU_SUB : ALU_ADD;
      F3_SLL:     return ALU_SLL;
      F3_SLT:     return ALU_SLT;
      F3_SLTU:    return ALU_SLTU;
      F3_XOR:     return ALU_XOR;
      F3_SR:      return alt ? ALU_SRA : ALU_SRL;
      F3_OR:      return ALU_OR;
      default:    return ALU_AND;
    endcase
  endfunction

  always_comb begin
    ctrl.rs1      = inst[19:15];
    ctrl.rs2      = inst[24:20];
    ctrl.rd       = inst[11:7];
    ctrl.imm      = imm_i;
    ctrl.b_is_imm = 1'b0;
    ctrl.a_is_pc  = 1'b0;
    ctrl.alu_op   = ALU_ADD;
    ctrl.npc_sel  = NPC_SEQ;
    ctrl.wb_sel   = WB_ALU;
    ctrl.reg_wen  = 1'b0;
    ctrl.mem_ren  = 1'b0;
    ctrl.mem_wen  = 1'b0;
    ctrl.mem_size = mem_size_e'(funct3[1:0]); // b, h, w match funct3 low bits.
    ctrl.mem_sext = ~funct3[2];
    ctrl.halt     = 1'b0;

    case (opcode)
      OP_LUI: begin
        ctrl.imm      = imm_u;
        ctrl.b_is_imm = 1'b1;
        ctrl.alu_op   = ALU_PASS_B;
        ctrl.reg_wen  = 1'b1;
      end
      OP_AUIPC: begin
        ctrl.imm      = imm_u;
        ctrl.a_is_pc  = 1'b1;
        ctrl.b_is_imm = 1'b1;
        ctrl.reg_wen  = 1'b1;
      end
      OP_JAL: begin
        ctrl.imm     = imm_j;
        ctrl.npc_sel = NPC_PCREL;
        ctrl.wb_sel  = WB_PC4;
        ctrl.reg_wen = 1'b1;
      end
      OP_JALR: begin
        ctrl.b_is_imm = 1'b1;
        if (funct3 == 3'd0) begin
          ctrl.npc_sel = NPC_REG;
          ctrl.wb_sel  = WB_PC4;
          ctrl.reg_wen = 1'b1;
        end
      end
      OP_BRANCH: begin
        ctrl.imm     = imm_b;
        ctrl.npc_sel = NPC_BRANCH;
        case (funct3)
          F3_BEQ:  ctrl.alu_op = ALU_EQ;
          F3_BNE:  ctrl.alu_op = ALU_NE;
          F3_BLT:  ctrl.alu_op = ALU_SLT;
          F3_BGE:  ctrl.alu_op = ALU_GE;
          F3_BLTU: ctrl.alu_op = ALU_SLTU;
          F3_BGEU: ctrl.alu_op = ALU_GEU;
          default: ctrl.npc_sel = NPC_SEQ; // reserved funct3 falls through as a no-op.
        endcase
      end
      OP_LOAD: begin
        ctrl.b_is_imm = 1'b1;
        ctrl.wb_sel   = WB_MEM;
        if (funct3[1:0] != 2'd3 && funct3 != 3'd6) begin
          ctrl.mem_ren = 1'b1;
          ctrl.reg_wen = 1'b1;
        end
      end
      OP_STORE: begin
        ctrl.imm      = imm_s;
        ctrl.b_is_imm = 1'b1;
        ctrl.mem_wen  = !funct3[2] && funct3[1:0] != 2'd3;
      end
      OP_IMM: begin
        ctrl.b_is_imm = 1'b1;
        ctrl.alu_op   = arith_op(funct3, inst[30] && funct3 == F3_SR);
        ctrl.reg_wen  = 1'b1;
      end
      OP_REG: begin
        ctrl.alu_op  = arith_op(funct3, inst[30]);
        ctrl.reg_wen = 1'b1;
      end
      OP_SYSTEM: ctrl.halt = (inst == ENC_EBREAK);
      default: ;
    endcase
  end

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module reg_file (
  input  logic             clk,
  input  logic             rst,
  input  logic [4:0]       rs1,
  input  logic [4:0]       rs2,
  input  logic [4:0]       rd,
  input  logic             wen,
  input  logic [`XLEN-1:0] wdata,
  output logic [`XLEN-1:0] src1,
  output logic [`XLEN-1:0] src2
);

  logic [`XLEN-1:0] regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0;
    end else if (wen && rd != 5'd0) begin
      regs[rd] <= wdata;
    end
  end

  assign src1 = (rs1 == 5'd0) ? '0 : regs[rs1]; // x0 reads zero.
  assign src2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module alu import isa_pkg::*; (
  input  alu_op_e          op,
  input  logic [`XLEN-1:0] a,
  input  logic [`XLEN-1:0] b,
  output logic [`XLEN-1:0] result
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_SLL:    result = a << shamt;
      ALU_SLT:    result = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      ALU_SLTU:   result = {{(`XLEN-1){1'b0}}, a < b};
      ALU_XOR:    result = a ^ b;
      ALU_SRL:    result = a >> shamt;
      ALU_SRA:    result = $unsigned($signed(a) >>> shamt);
      ALU_OR:     result = a | b;
      ALU_AND:    result = a & b;
      ALU_PASS_B: result = b; // lui.
      ALU_EQ:     result = {{(`XLEN-1){1'b0}}, a == b};
      ALU_NE:     result = {{(`XLEN-1){1'b0}}, a != b};
      ALU_GE:     result = {{(`XLEN-1){1'b0}}, $signed(a) >= $signed(b)};
      ALU_GEU:    result = {{(`XLEN-1){1'b0}}, a >= b};
      default:    result = '0;
    endcase
  end

endmodule

// ==== src/data_mem.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module data_mem import isa_pkg::*; (
  input  logic             clk,
  input  logic             ren,
  input  logic             wen,
  input  mem_size_e        size,
  input  logic             sext,
  input  logic [`XLEN-1:0] addr,
  input  logic [`XLEN-1:0] wdata,
  output logic [`XLEN-1:0] rdata
);

  localparam int AW = $clog2(`DMEM_BYTES);

  logic [7:0]    mem [`DMEM_BYTES];
  logic [AW-1:0] a0;
  logic [31:0]   word;

  assign a0 = addr[AW-1:0];

  // little-endian view of the four bytes at addr.
  assign word = {mem[a0 + AW'(3)], mem[a0 + AW'(2)], mem[a0 + AW'(1)], mem[a0]};

  always_ff @(posedge clk) begin
    if (wen) begin
      mem[a0] <= wdata[7:0];
      if (size != MEM_B) mem[a0 + AW'(1)] <= wdata[15:8];
      if (size == MEM_W) begin
        mem[a0 + AW'(2)] <= wdata[23:16];
        mem[a0 + AW'(3)] <= wdata[31:24];
      end
    end
  end

  always_comb begin
    if (!ren) begin
      rdata = '0;
    end else begin
      case (size)
        MEM_B:   rdata = {{(`XLEN-8){sext & word[7]}}, word[7:0]};
        MEM_H:   rdata = {{(`XLEN-16){sext & word[15]}}, word[15:0]};
        default: rdata = word;
      endcase
    end
  end

  a_half_aligned: assert property (@(posedge clk) (ren || wen) && size == MEM_H |-> !addr[0])
    else $error("misaligned half access at %h", addr);

  a_word_aligned: assert property (@(posedge clk)
    (ren || wen) && size == MEM_W |-> addr[1:0] == 2'b00)
    else $error("misaligned word access at %h", addr);

endmodule

// ==== src/rv_core.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module rv_core import isa_pkg::*, core_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  imem_load_t imem_load,
  output logic       halt,
  output retire_t    retire
);

  logic [`XLEN-1:0] pc;
  logic [31:0]      inst;
  ctrl_t            ctrl;
  logic [`XLEN-1:0] src1;
  logic [`XLEN-1:0] src2;
  logic [`XLEN-1:0] alu_a;
  logic [`XLEN-1:0] alu_b;
  logic [`XLEN-1:0] alu_result;
  logic [`XLEN-1:0] mem_rdata;
  logic [`XLEN-1:0] wb_data;
  logic             halted_q;
  logic             active;
  logic             reg_wen;

  always_ff @(posedge clk) begin
    if (rst) begin
      halted_q <= 1'b0;
    end else if (ctrl.halt) begin
      halted_q <= 1'b1; // sticky until reset.
    end
  end

  assign halt    = halted_q | ctrl.halt;
  assign active  = !rst && !halt;
  assign reg_wen = ctrl.reg_wen & active;

  fetch_unit u_fetch_unit (
    .clk        (clk),
    .rst        (rst),
    .imem_load  (imem_load),
    .stall      (halt),
    .npc_sel    (ctrl.npc_sel),
    .imm        (ctrl.imm),
    .alu_result (alu_result),
    .pc         (pc),
    .inst       (inst)
  );

  decode_unit u_decode_unit (
    .inst (inst),
    .ctrl (ctrl)
  );

  reg_file u_reg_file (
    .clk   (clk),
    .rst   (rst),
    .rs1   (ctrl.rs1),
    .rs2   (ctrl.rs2),
    .rd    (ctrl.rd),
    .wen   (reg_wen),
    .wdata (wb_data),
    .src1  (src1),
    .src2  (src2)
  );

  assign alu_a = ctrl.a_is_pc ? pc : src1;
  assign alu_b = ctrl.b_is_imm ? ctrl.imm : src2;

  alu u_alu (
    .op     (ctrl.alu_op),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_result)
  );

  data_mem u_data_mem (
    .clk   (clk),
    .ren   (ctrl.mem_ren & active),
    .wen   (ctrl.mem_wen & active),
    .size  (ctrl.mem_size),
    .sext  (ctrl.mem_sext),
    .addr  (alu_result),
    .wdata (src2),
    .rdata (mem_rdata)
  );

  always_comb begin
    case (ctrl.wb_sel)
      WB_ALU:   wb_data = alu_result;
      WB_PC4:   wb_data = pc + `XLEN'd4; // link address.
      default:  wb_data = mem_rdata;
    endcase
  end

  always_comb begin
    retire.valid   = active;
    retire.pc      = pc;
    retire.inst    = inst;
    retire.rd      = ctrl.rd;
    retire.reg_wen = reg_wen;
    retire.wdata   = wb_data;
  end

  a_halt_sticky: assert property (@(posedge clk) disable iff (rst) halt |=> halt && !retire.valid)
    else $error("core left halt without reset");

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
  parameter realtime PERIOD = 100ns
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

endmodule

// ==== test/tb_rv_core.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module tb_rv_core import isa_pkg::*, core_pkg::*; ();

  localparam int AW = $clog2(`IMEM_WORDS);
  localparam int MAX_CYCLES = 2000; // six programs of at most ~60 words plus reset and halt checks.
  localparam logic [31:0] DBASE = 32'h100;

  logic        clk;
  logic        rst;
  imem_load_t  imem_load;
  logic        halt;
  retire_t     retire;

  logic [31:0] prog [$];
  logic [31:0] exp_pc [$];
  logic [31:0] exp_inst [$];
  logic [31:0] exp_wd [$];
  bit          exp_chk [$]; // instruction writes a register.
  logic [31:0] ret_pc [$];
  logic [31:0] ret_inst [$];
  logic [31:0] ret_wd [$];
  logic [4:0]  ret_rd [$];
  bit          ret_wen [$];
  logic [7:0]  dm [`DMEM_BYTES]; // expected data memory contents.
  logic [31:0] seed = 32'h5d7c;
  int          cycles = 0;

  tb_clock u_tb_clock (.clk(clk));

  rv_core u_rv_core (
    .clk       (clk),
    .rst       (rst),
    .imem_load (imem_load),
    .halt      (halt),
    .retire    (retire)
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > MAX_CYCLES) begin
      $display("timeout: the run went past %0d cycles", MAX_CYCLES);
      $display("STATUS: FAIL");
      $fatal(1);
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic check(input logic [31:0] got, input logic [31:0] expv, input string msg);
    if (got !== expv) begin
      $display("Fail at %0t: %s, got %h expected %h", $time, msg, got, expv);
      $display("STATUS: FAIL");
      $fatal(1);
    end
  endtask

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // rv32i arithmetic by funct3, alt selects sub and sra.
  function automatic logic [31:0] rv_alu(input logic [2:0] f3, input bit alt,
                                         input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic bit branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic [31:0] cur_pc();
    return 32'(4 * prog.size());
  endfunction

  task automatic new_prog();
    prog.delete();
    exp_pc.delete();
    exp_inst.delete();
    exp_wd.delete();
    exp_chk.delete();
  endtask

  task automatic place(input logic [31:0] w);
    if (prog.size() >= `IMEM_WORDS) begin
      $display("program does not fit in instruction memory");
      $display("STATUS: FAIL");
      $fatal(1);
    end
    prog.push_back(w);
  endtask

  task automatic emit(input logic [31:0] w, input logic [31:0] wd, input bit chk);
    exp_pc.push_back(cur_pc());
    exp_inst.push_back(w);
    exp_wd.push_back(wd);
    exp_chk.push_back(chk);
    place(w);
  endtask

  task automatic li(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] up;
    up = v + 32'h800; // addi sign-extends the low 12 bits.
    emit({up[31:12], rd, 7'b0110111}, {up[31:12], 12'b0}, 1'b1);
    emit(i_type(v[11:0], rd, 3'd0, rd, 7'b0010011), v, 1'b1);
  endtask

  task automatic store(input logic [2:0] f3, input logic [4:0] rs2, input logic [31:0] v,
                       input logic [11:0] off);
    int a;
    a = int'(DBASE) + int'(off);
    for (int i = 0; i < (1 << f3); i++) dm[a + i] = v[8*i +: 8];
    emit(s_type(off, rs2, 5'd1, f3), 32'h0, 1'b0);
  endtask

  task automatic load(input logic [2:0] f3, input logic [11:0] off);
    int          a;
    logic [31:0] w;
    logic [31:0] v;
    a = int'(DBASE) + int'(off);
    w = {dm[a+3], dm[a+2], dm[a+1], dm[a]};
    case (f3)
      3'd0: v = {{24{w[7]}}, w[7:0]};
      3'd1: v = {{16{w[15]}}, w[15:0]};
      3'd4: v = {24'b0, w[7:0]};
      3'd5: v = {16'b0, w[15:0]};
      default: v = w;
    endcase
    emit(i_type(off, 5'd1, f3, 5'd4, 7'b0000011), v, 1'b1);
  endtask

  // load (optionally), reset, run to halt or stop_after retires, then compare.
  task automatic run_prog(input int stop_after, input bit do_load);
    int n;
    ret_pc.delete();
    ret_inst.delete();
    ret_wd.delete();
    ret_rd.delete();
    ret_wen.delete();
    @(posedge clk);
    rst <= 1'b1;
    if (do_load) begin
      foreach (prog[i]) begin
        imem_load <= '{en: 1'b1, addr: AW'(i), data: prog[i]};
        @(posedge clk);
      end
    end
    imem_load <= '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    while (1) begin
      @(negedge clk);
      if (retire.valid) begin
        ret_pc.push_back(retire.pc);
        ret_inst.push_back(retire.inst);
        ret_wd.push_back(retire.wdata);
        ret_rd.push_back(retire.rd);
        ret_wen.push_back(retire.reg_wen);
      end
      if (halt || (stop_after > 0 && ret_pc.size() == stop_after)) break;
    end
    if (halt) begin
      repeat (20) begin
        @(negedge clk);
        check(32'(retire.valid), 32'h0, "retire after halt");
        check(32'(halt), 32'h1, "halt dropped");
      end
    end
    n = (stop_after > 0) ? stop_after : exp_pc.size();
    check(32'(ret_pc.size()), 32'(n), "retire count");
    for (int i = 0; i < n; i++) begin
      check(ret_pc[i], exp_pc[i], $sformatf("pc of retire %0d", i));
      check(ret_inst[i], exp_inst[i], $sformatf("inst of retire %0d", i));
      check(32'(ret_wen[i]), 32'(exp_chk[i]), $sformatf("reg_wen of retire %0d", i));
      if (exp_chk[i]) begin
        check(32'(ret_rd[i]), 32'(exp_inst[i][11:7]), $sformatf("rd of retire %0d", i));
        check(ret_wd[i], exp_wd[i], $sformatf("wdata of retire %0d", i));
      end
    end
  endtask

  task automatic alu_ops();
    logic [31:0] a;
    logic [31:0] b;
    logic [11:0] imm;
    new_prog();
    seed = xorshift(seed);
    a = seed | 32'h8000_0000; // negative, so signed and unsigned ops differ.
    seed = xorshift(seed);
    b = seed;
    li(5'd1, a);
    li(5'd2, b);
    for (int f = 0; f < 8; f++) begin
      for (int alt = 0; alt < 2; alt++) begin
        if (alt == 0 || f == 0 || f == 5)
          emit(r_type(alt ? 7'b0100000 : 7'b0, 5'd2, 5'd1, 3'(f), 5'd3),
               rv_alu(3'(f), alt[0], a, b), 1'b1);
      end
    end
    for (int f = 0; f < 8; f++) begin
      for (int alt = 0; alt < 2; alt++) begin
        if (alt == 0 || f == 5) begin
          seed = xorshift(seed);
          imm = seed[11:0];
          if (f == 1 || f == 5) imm = {alt ? 7'b0100000 : 7'b0, seed[4:0]};
          emit(i_type(imm, 5'd1, 3'(f), 5'd3, 7'b0010011),
               rv_alu(3'(f), alt[0], a, {{20{imm[11]}}, imm}), 1'b1);
        end
      end
    end
    place(ENC_EBREAK);
    run_prog(0, 1'b1);
  endtask

  task automatic x0_writes();
    new_prog();
    emit(i_type(12'd5, 5'd0, 3'd0, 5'd0, 7'b0010011), 32'd5, 1'b1);
    emit(r_type(7'b0, 5'd0, 5'd0, 3'd0, 5'd5), 32'd0, 1'b1);
    place(ENC_EBREAK);
    run_prog(0, 1'b1);
    check(32'(ret_rd[0]), 32'd0, "rd of x0 write");
  endtask

  task automatic branches_and_jumps();
    logic [31:0] xv [3];
    logic [31:0] poison;
    logic [31:0] t;
    int          f3s [6];
    int          pairs [3][2];
    bit          tk;
    xv = '{32'h0, 32'hffff_fffd, 32'h5};
    f3s = '{0, 1, 4, 5, 6, 7};
    pairs = '{'{1, 1}, '{1, 2}, '{2, 1}};
    poison = i_type(12'd1, 5'd0, 3'd0, 5'd10, 7'b0010011);
    new_prog();
    li(5'd1, xv[1]);
    li(5'd2, xv[2]);
    foreach (f3s[k]) begin
      foreach (pairs[p]) begin
        tk = branch_taken(3'(f3s[k]), xv[pairs[p][0]], xv[pairs[p][1]]);
        emit(b_type(13'd8, 5'(pairs[p][1]), 5'(pairs[p][0]), 3'(f3s[k])), 32'h0, 1'b0);
        if (tk) place(poison);
        else emit(poison, 32'd1, 1'b1);
      end
    end
    emit(j_type(21'd8, 5'd5), cur_pc() + 32'd4, 1'b1);
    place(poison);
    t = cur_pc() + 32'd16; // past li, jalr and one skipped word.
    li(5'd6, t);
    emit(i_type(12'd1, 5'd6, 3'd0, 5'd7, 7'b1100111), cur_pc() + 32'd4, 1'b1);
    place(poison);
    place(ENC_EBREAK);
    run_prog(0, 1'b1);
  endtask

  task automatic loads_and_stores();
    new_prog();
    li(5'd1, DBASE);
    li(5'd2, 32'h8765_4321);
    li(5'd3, 32'ha5b6_c7f8);
    store(3'd2, 5'd2, 32'h8765_4321, 12'd0);
    store(3'd1, 5'd2, 32'h8765_4321, 12'd6);
    store(3'd0, 5'd3, 32'ha5b6_c7f8, 12'd8);
    store(3'd0, 5'd2, 32'h8765_4321, 12'd9);
    store(3'd1, 5'd3, 32'ha5b6_c7f8, 12'd10);
    load(3'd2, 12'd0);
    load(3'd0, 12'd3);
    load(3'd4, 12'd3);
    load(3'd1, 12'd2);
    load(3'd5, 12'd2);
    load(3'd1, 12'd6);
    load(3'd0, 12'd8);
    load(3'd4, 12'd9);
    load(3'd5, 12'd10);
    load(3'd1, 12'd10);
    load(3'd2, 12'd8);
    place(ENC_EBREAK);
    run_prog(0, 1'b1);
  endtask

  task automatic ebreak_halt();
    new_prog();
    emit(i_type(12'd3, 5'd0, 3'd0, 5'd8, 7'b0010011), 32'd3, 1'b1);
    place(ENC_EBREAK);
    place(i_type(12'd9, 5'd0, 3'd0, 5'd8, 7'b0010011)); // never retires.
    run_prog(0, 1'b1);
  endtask

  task automatic mid_run_reset();
    new_prog();
    for (int i = 1; i <= 8; i++)
      emit(i_type(12'd1, 5'd1, 3'd0, 5'd1, 7'b0010011), 32'(i), 1'b1);
    place(ENC_EBREAK);
    run_prog(3, 1'b1);
    run_prog(0, 1'b0);
  endtask

  initial begin
    rst = 1'b1;
    imem_load = '0;
    alu_ops();
    x0_writes();
    branches_and_jumps();
    loads_and_stores();
    ebreak_halt();
    mid_run_reset();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+src
src/isa_pkg.sv
src/core_pkg.sv
src/fetch_unit.sv
src/decode_unit.sv
src/reg_file.sv
src/alu.sv
src/data_mem.sv
src/rv_core.sv
test/tb_clock.sv
test/tb_rv_core.sv

// ==== Makefile ====
VERILATOR  = verilator
FLAGS      = --timing --assert
TOP        = tb_rv_core
RTL_TOP    = rv_core
FILELIST   = files.f
OBJ_DIR    = obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf $(OBJ_DIR)
